// ==== layer2_mac_array.f ====
source/layer2_pkg.sv
source/dot_product_channel.sv
source/wb_register_file.sv
source/layer2_mac_array.sv
testbench/tb_checker.sv
testbench/tb_layer2.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

# Build and run the layer2 testbench with Verilator
LOG=sim.log

verilator --binary --timing --assert --top-module tb_layer2 \
	-f layer2_mac_array.f -o sim_layer2 > "$LOG" 2>&1 \
	&& ./obj_dir/sim_layer2 >> "$LOG" 2>&1 \
	|| echo "STATUS: FAIL" >> "$LOG"

cat "$LOG"

grep -q "STATUS: FAIL" "$LOG" \
	&& { echo "Simulation failed, see $LOG"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }

// ==== source/dot_product_channel.sv ====
`timescale 1ns/100ps

module dot_product_channel (
	input  logic                  clk,
	input  logic                  rst,
	input  layer2_pkg::lane_vec_t samples,
	input  layer2_pkg::lane_vec_t weights,
	output layer2_pkg::sample_t   result
);

	import layer2_pkg::*;

	// Full lane products
	product_t  products [NUM_LANES];

	// Truncated products, before and after the register
	lane_vec_t trunc_d;
	lane_vec_t trunc_q;

	// Adder tree levels
	sample_t   level1 [NUM_LANES/2];
	sample_t   level2 [NUM_LANES/4];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lane multipliers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// 16x16 signed gives a Q10.20 product
	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
		begin
			products[i] = $signed(samples[i]) * $signed(weights[i]);
		end
	end

	// Back to Q5.10, upper bits dropped
	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
		begin
			trunc_d[i] = products[i][FRAC_BITS +: SAMPLE_W];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Product register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			trunc_q <= '0;
		end
		else
		begin
			trunc_q <= trunc_d;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Adder tree
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Every sum is 16 bits wide and wraps on overflow

	// Level 1, neighbouring lanes
	always_comb
	begin
		for (int i = 0; i < NUM_LANES/2; i++)
		begin
			level1[i] = trunc_q[2*i] + trunc_q[2*i+1];
		end
	end

	// Level 2, pairs of pairs
	always_comb
	begin
		for (int i = 0; i < NUM_LANES/4; i++)
		begin
			level2[i] = level1[2*i] + level1[2*i+1];
		end
	end

	// Level 3, final sum straight off the register
	assign result = level2[0] + level2[1];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// An X on a weight or input register upstream would surface here
	a_result_known: assert property (
		@(posedge clk) disable iff (rst)
		!$isunknown(result)
	) else $error("dot_product_channel: result is unknown");

endmodule

// ==== source/layer2_mac_array.sv ====
`timescale 1ns/100ps

module layer2_mac_array (
	input  logic                clk,
	input  logic                rst,
	input  layer2_pkg::wb_req_t wb_req,
	output layer2_pkg::wb_rsp_t wb_rsp
);

	import layer2_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Internal nets
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Shared input vector, fanned out to every channel
	lane_vec_t samples;

	// One weight vector per channel
	lane_vec_t weights [NUM_CHANNELS];

	// Channel sums back to the read mux
	sample_t   results [NUM_CHANNELS];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus slave
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	wb_register_file u_regs (
		.clk     (clk),
		.rst     (rst),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.samples (samples),
		.weights (weights),
		.results (results)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// MAC channels
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Results trail the registers by one product-register edge
	for (genvar c = 0; c < NUM_CHANNELS; c++)
	begin : g_channel
		dot_product_channel u_channel (
			.clk     (clk),
			.rst     (rst),
			.samples (samples),
			.weights (weights[c]),
			.result  (results[c])
		);
	end

endmodule

// ==== source/layer2_pkg.sv ====
package layer2_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Datapath widths and counts
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int SAMPLE_W     = 16;
	localparam int PRODUCT_W    = 2 * SAMPLE_W;
	localparam int NUM_LANES    = 8;
	localparam int NUM_CHANNELS = 8;

	// Q5.10 samples, so the kept slice starts at bit 10
	localparam int FRAC_BITS    = 10;

	localparam int LANE_IDX_W   = $clog2(NUM_LANES);
	localparam int CHAN_IDX_W   = $clog2(NUM_CHANNELS);
	localparam int ADR_W        = 7;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Data types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Signed fixed point sample or weight
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Full precision lane product
	typedef logic signed [PRODUCT_W-1:0] product_t;

	// Eight lanes side by side, lane 0 in the low bits
	typedef sample_t [NUM_LANES-1:0] lane_vec_t;

	// Bus word address
	typedef logic [ADR_W-1:0] adr_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register map (word addresses)
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Input lanes 0..7
	localparam adr_t ADR_INPUT_BASE  = 7'h00;

	// Channel c, lane l at base + c*8 + l
	localparam adr_t ADR_WEIGHT_BASE = 7'h08;

	// Channel results, read only
	localparam adr_t ADR_RESULT_BASE = 7'h48;

	// First unmapped word
	localparam adr_t ADR_LIMIT       = 7'h50;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Wishbone classic bundles
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Master to slave
	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		adr_t    adr;
		sample_t dat;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic    ack;
		sample_t dat;
	} wb_rsp_t;

endpackage

// ==== source/wb_register_file.sv ====
`timescale 1ns/100ps

module wb_register_file (
	input  logic                  clk,
	input  logic                  rst,
	input  layer2_pkg::wb_req_t   wb_req,
	output layer2_pkg::wb_rsp_t   wb_rsp,
	output layer2_pkg::lane_vec_t samples,
	output layer2_pkg::lane_vec_t weights [layer2_pkg::NUM_CHANNELS],
	input  layer2_pkg::sample_t   results [layer2_pkg::NUM_CHANNELS]
);

	import layer2_pkg::*;

	// Stored vectors
	lane_vec_t input_q;
	lane_vec_t weight_q [NUM_CHANNELS];

	// Response registers
	logic      ack_q;
	sample_t   rdat_q;

	// New request this cycle
	logic      req_valid;

	// Region decode
	logic      in_input;
	logic      in_weight;
	logic      in_result;

	// Offsets into each region
	adr_t      input_ofs;
	adr_t      weight_ofs;
	adr_t      result_ofs;

	logic [LANE_IDX_W-1:0] in_lane;
	logic [LANE_IDX_W-1:0] wt_lane;
	logic [CHAN_IDX_W-1:0] wt_chan;
	logic [CHAN_IDX_W-1:0] res_chan;

	// Read mux output
	sample_t   rd_value;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// ack_q low keeps a held request from being taken twice
	assign req_valid = wb_req.cyc && wb_req.stb && !ack_q;

	assign in_input  = (wb_req.adr < ADR_WEIGHT_BASE);
	assign in_weight = (wb_req.adr >= ADR_WEIGHT_BASE) && (wb_req.adr < ADR_RESULT_BASE);
	assign in_result = (wb_req.adr >= ADR_RESULT_BASE) && (wb_req.adr < ADR_LIMIT);

	assign input_ofs  = wb_req.adr - ADR_INPUT_BASE;
	assign weight_ofs = wb_req.adr - ADR_WEIGHT_BASE;
	assign result_ofs = wb_req.adr - ADR_RESULT_BASE;

	assign in_lane  = input_ofs[LANE_IDX_W-1:0];
	assign wt_lane  = weight_ofs[LANE_IDX_W-1:0];
	// Channel sits just above the lane bits
	assign wt_chan  = weight_ofs[LANE_IDX_W +: CHAN_IDX_W];
	assign res_chan = result_ofs[CHAN_IDX_W-1:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Input and weight storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Writes to the result and unmapped regions fall through
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			input_q  <= '0;
			weight_q <= '{default: '0};
		end
		else if (req_valid && wb_req.we)
		begin
			if (in_input)
			begin
				input_q[in_lane] <= wb_req.dat;
			end
			else if (in_weight)
			begin
				weight_q[wt_chan][wt_lane] <= wb_req.dat;
			end
		end
	end

	assign samples = input_q;
	assign weights = weight_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read path and ack
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Unmapped words read as zero
	always_comb
	begin
		rd_value = '0;
		if (in_input)
		begin
			rd_value = input_q[in_lane];
		end
		else if (in_weight)
		begin
			rd_value = weight_q[wt_chan][wt_lane];
		end
		else if (in_result)
		begin
			rd_value = results[res_chan];
		end
	end

	// One cycle ack; read data captured on the same edge
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			ack_q  <= 1'b0;
			rdat_q <= '0;
		end
		else
		begin
			ack_q <= req_valid;
			if (req_valid && !wb_req.we)
			begin
				rdat_q <= rd_value;
			end
		end
	end

	assign wb_rsp = '{ack: ack_q, dat: rdat_q};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Classic cycle, so never back to back
	a_ack_single: assert property (
		@(posedge clk) disable iff (rst)
		ack_q |=> !ack_q
	) else $error("wb_register_file: ack high for two cycles");

	// Each ack answers a strobe from the previous cycle
	a_ack_after_req: assert property (
		@(posedge clk) disable iff (rst)
		$rose(ack_q) |-> $past(wb_req.cyc && wb_req.stb)
	) else $error("wb_register_file: ack without request");

endmodule

// ==== testbench/tb_checker.sv ====
`timescale 1ns/100ps

module tb_checker (
	input  logic                clk,
	input  logic                rst,
	input  layer2_pkg::wb_req_t wb_req,
	input  layer2_pkg::wb_rsp_t wb_rsp,
	input  logic                test_done,
	input  logic [8*16-1:0]     test_name,
	output int                  tests_passed,
	output int                  tests_failed
);

	import layer2_pkg::*;

	// Shadow of every accepted write
	lane_vec_t shadow_input;
	lane_vec_t shadow_weights [NUM_CHANNELS];

	logic      ack_prev;
	int        reads_in_test;
	int        errors_in_test;
	sample_t   expected;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Product bits 25..10 per lane, summed modulo 2^16
	function automatic sample_t channel_sum(input lane_vec_t a, input lane_vec_t b);
		int      prod;
		sample_t acc;
		acc = '0;
		for (int l = 0; l < NUM_LANES; l++)
		begin
			prod = int'(a[l]) * int'(b[l]);
			acc  = acc + sample_t'(prod >>> FRAC_BITS);
		end
		return acc;
	endfunction

	function automatic sample_t expected_read(input adr_t adr);
		adr_t ofs;
		if (adr < ADR_WEIGHT_BASE)
		begin
			return shadow_input[adr[2:0]];
		end
		if (adr < ADR_RESULT_BASE)
		begin
			ofs = adr - ADR_WEIGHT_BASE;
			return shadow_weights[ofs[5:3]][ofs[2:0]];
		end
		if (adr < ADR_LIMIT)
		begin
			ofs = adr - ADR_RESULT_BASE;
			return channel_sum(shadow_input, shadow_weights[ofs[2:0]]);
		end
		return '0;
	endfunction

	// Result and unmapped writes leave the shadow alone
	function automatic void record_write(input adr_t adr, input sample_t dat);
		adr_t ofs;
		if (adr < ADR_WEIGHT_BASE)
		begin
			shadow_input[adr[2:0]] = dat;
		end
		else if (adr < ADR_RESULT_BASE)
		begin
			ofs = adr - ADR_WEIGHT_BASE;
			shadow_weights[ofs[5:3]][ofs[2:0]] = dat;
		end
	endfunction

	initial
	begin
		shadow_input   = '0;
		shadow_weights = '{default: '0};
		ack_prev       = 1'b0;
		reads_in_test  = 0;
		errors_in_test = 0;
		tests_passed   = 0;
		tests_failed   = 0;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus monitor, sampled mid cycle
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (wb_rsp.ack && ack_prev)
			begin
				$display("ERROR %0s: ack stayed high for two cycles", test_name);
				errors_in_test++;
			end
			if (wb_rsp.ack && !(wb_req.cyc && wb_req.stb))
			begin
				$display("ERROR %0s: ack seen with no active request", test_name);
				errors_in_test++;
			end
			else if (wb_rsp.ack && wb_req.we)
			begin
				record_write(wb_req.adr, wb_req.dat);
			end
			else if (wb_rsp.ack)
			begin
				expected = expected_read(wb_req.adr);
				reads_in_test++;
				if (wb_rsp.dat !== expected)
				begin
					$display("MISMATCH %0s adr 0x%02h expected 0x%04h actual 0x%04h",
						test_name, wb_req.adr, expected, wb_rsp.dat);
					errors_in_test++;
				end
			end
			ack_prev = wb_rsp.ack;

			// One line per finished test
			if (test_done)
			begin
				if (errors_in_test == 0)
				begin
					tests_passed++;
				end
				else
				begin
					tests_failed++;
				end
				$display("Test %0s: %0s, %0d reads checked, %0d errors", test_name,
					(errors_in_test == 0) ? "passed" : "failed", reads_in_test, errors_in_test);
				reads_in_test  = 0;
				errors_in_test = 0;
			end
		end
	end

endmodule

// ==== testbench/tb_layer2.sv ====
`timescale 1ns/100ps

module tb_layer2;

	import layer2_pkg::*;

	localparam int          CLK_PERIOD      = 8;
	localparam int          NUM_ROWS        = 8;
	localparam int          NAME_W          = 8 * 16;
	localparam int unsigned SEED            = 32'hde90_2da8;
	// Writes, ignored writes, readback, result reads and unmapped reads per row
	localparam int          XFERS_PER_ROW   = 2 * NUM_LANES * (NUM_CHANNELS + 1) + NUM_CHANNELS + 4;
	localparam int          WATCHDOG_CYCLES = (NUM_ROWS + 1) * XFERS_PER_ROW * 4 + 200;

	logic              clk;
	logic              rst;
	wb_req_t           wb_req;
	wb_rsp_t           wb_rsp;
	logic              test_done;
	logic [NAME_W-1:0] test_name;
	int                tests_passed;
	int                tests_failed;

	// Stimulus table
	logic [NAME_W-1:0] row_name    [NUM_ROWS];
	lane_vec_t         row_input   [NUM_ROWS];
	lane_vec_t         row_weights [NUM_ROWS][NUM_CHANNELS];
	logic              row_random  [NUM_ROWS];

	layer2_mac_array DUT (
		.clk    (clk),
		.rst    (rst),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	tb_checker u_checker (
		.clk          (clk),
		.rst          (rst),
		.wb_req       (wb_req),
		.wb_rsp       (wb_rsp),
		.test_done    (test_done),
		.test_name    (test_name),
		.tests_passed (tests_passed),
		.tests_failed (tests_failed)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Table helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Channel c gets the weight pattern turned by c lanes
	function automatic lane_vec_t rotate_lanes(input lane_vec_t v, input int n);
		lane_vec_t r;
		for (int l = 0; l < NUM_LANES; l++)
		begin
			r[l] = v[(l + n) % NUM_LANES];
		end
		return r;
	endfunction

	task automatic set_row(input int r, input logic [NAME_W-1:0] name, input lane_vec_t in_vec,
		input lane_vec_t w_pattern, input logic rnd);
		row_name[r]   = name;
		row_input[r]  = in_vec;
		row_random[r] = rnd;
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			row_weights[r][c] = rotate_lanes(w_pattern, c);
		end
	endtask

	task automatic fill_random_row(input int r);
		for (int l = 0; l < NUM_LANES; l++)
		begin
			row_input[r][l] = sample_t'($urandom());
			for (int c = 0; c < NUM_CHANNELS; c++)
			begin
				row_weights[r][c][l] = sample_t'($urandom());
			end
		end
	endtask

	function automatic adr_t weight_adr(input int c, input int l);
		return adr_t'(int'(ADR_WEIGHT_BASE) + c * NUM_LANES + l);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus driver
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One classic transfer, request held until ack
	task automatic bus_transfer(input logic we, input adr_t adr, input sample_t dat);
		@(posedge clk);
		#1;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = dat;
		@(negedge clk);
		while (!wb_rsp.ack)
		begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		wb_req = '0;
	endtask

	task automatic finish_test();
		@(posedge clk);
		#1;
		test_done = 1'b1;
		@(posedge clk);
		#1;
		test_done = 1'b0;
	endtask

	task automatic run_row(input int r);
		if (row_random[r])
		begin
			fill_random_row(r);
		end
		test_name = row_name[r];
		for (int l = 0; l < NUM_LANES; l++)
		begin
			bus_transfer(1'b1, adr_t'(int'(ADR_INPUT_BASE) + l), row_input[r][l]);
		end
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			for (int l = 0; l < NUM_LANES; l++)
			begin
				bus_transfer(1'b1, weight_adr(c, l), row_weights[r][c][l]);
			end
		end
		// Neither of these may land anywhere
		bus_transfer(1'b1, adr_t'(int'(ADR_RESULT_BASE) + r % NUM_CHANNELS), 16'h5a5a);
		bus_transfer(1'b1, adr_t'(int'(ADR_LIMIT) + r), 16'h1234);
		// Write edge, then product register edge
		repeat (2) @(posedge clk);
		for (int l = 0; l < NUM_LANES; l++)
		begin
			bus_transfer(1'b0, adr_t'(int'(ADR_INPUT_BASE) + l), '0);
		end
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			for (int l = 0; l < NUM_LANES; l++)
			begin
				bus_transfer(1'b0, weight_adr(c, l), '0);
			end
		end
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			bus_transfer(1'b0, adr_t'(int'(ADR_RESULT_BASE) + c), '0);
		end
		bus_transfer(1'b0, adr_t'(int'(ADR_LIMIT) + r), '0);
		bus_transfer(1'b0, 7'h7f, '0);
		finish_test();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		clk       = 1'b0;
		rst       = 1'b1;
		wb_req    = '0;
		test_done = 1'b0;
		test_name = '0;
		void'($urandom(SEED));

		set_row(0, "unit_weights", {16'h1000, 16'h0e00, 16'h0c00, 16'h0a00,
			16'h0800, 16'h0600, 16'h0400, 16'h0200}, {NUM_LANES{16'h0400}}, 1'b0);
		set_row(1, "mixed_small", {16'hfc00, 16'h0200, 16'h0100, 16'hff00,
			16'h0800, 16'hf800, 16'h0080, 16'h0040}, {16'h0400, 16'hfe00, 16'h0c00,
			16'h0100, 16'hff80, 16'h0300, 16'hf400, 16'h0010}, 1'b0);
		set_row(2, "all_neg_max", {NUM_LANES{16'h8000}}, {NUM_LANES{16'h8000}}, 1'b0);
		set_row(3, "all_pos_max", {NUM_LANES{16'h7fff}}, {NUM_LANES{16'h7fff}}, 1'b0);
		set_row(4, "mixed_extreme", {4{16'h7fff, 16'h8000}},
			{2{16'h8000, 16'h8000, 16'h7fff, 16'h7fff}}, 1'b0);
		set_row(5, "random_a", '0, '0, 1'b1);
		set_row(6, "random_b", '0, '0, 1'b1);
		set_row(7, "random_c", '0, '0, 1'b1);

		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		// Everything reads zero out of reset
		test_name = "after_reset";
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			bus_transfer(1'b0, adr_t'(int'(ADR_RESULT_BASE) + c), '0);
		end
		bus_transfer(1'b0, adr_t'(int'(ADR_INPUT_BASE) + 3), '0);
		bus_transfer(1'b0, weight_adr(5, 6), '0);
		finish_test();

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			run_row(r);
		end

		repeat (4) @(posedge clk);
		$display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0)
		begin
			$display("STATUS: PASS");
		end
		else
		begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule
